/* verilog/ps2_kbd_pkg.sv */
package ps2_kbd_pkg;

    // a key code is read as one map index or as ext flag plus scan byte
    typedef union packed {
        logic [8:0] raw;                        // index into key map
        struct packed {
            logic       ext;                    // came after E0
            logic [7:0] scan;                   // scan byte itself
        } fields;
    } key_code_u;

    localparam logic [7:0] SCAN_EXT   = 8'hE0;  // extended prefix
    localparam logic [7:0] SCAN_BREAK = 8'hF0;  // release prefix

    localparam logic [8:0] LEFT_SHIFT_CODE  = 9'h012;
    localparam logic [8:0] RIGHT_SHIFT_CODE = 9'h059;

    // 0..9 main row, 10..19 keypad; entry i and i+10 give the same digit
    localparam logic [8:0] DIGIT_CODES [20] = '{
        9'h045, 9'h016, 9'h01E, 9'h026, 9'h025,
        9'h02E, 9'h036, 9'h03D, 9'h03E, 9'h046,
        9'h070, 9'h069, 9'h072, 9'h07A, 9'h06B,
        9'h073, 9'h074, 9'h06C, 9'h075, 9'h07D
    };

    localparam logic [3:0] BLANK_NIBBLE = 4'hF;     // empty position

    // active low, bit 0 is segment a, bit 6 is segment g
    localparam logic [6:0] SEG_PATTERNS [11] = '{
        7'h40,  // 0
        7'h79,  // 1
        7'h24,  // 2
        7'h30,  // 3
        7'h19,  // 4
        7'h12,  // 5
        7'h02,  // 6
        7'h78,  // 7
        7'h00,  // 8
        7'h10,  // 9
        7'h7F   // blank
    };

    localparam int FILTER_LEN    = 8;   // stable samples before a ps2 clock edge counts
    localparam int SCAN_DIV_BITS = 4;   // 16 cycles per digit

endpackage

/* verilog/ps2_rx.sv */
`timescale 1ns/100ps

module ps2_rx import ps2_kbd_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    logic [1:0]            clk_sync;    // two-flop synchronizers
    logic [1:0]            data_sync;
    logic [FILTER_LEN-1:0] clk_hist;    // recent synced clock samples
    logic                  clk_filt;    // debounced ps2 clock level
    logic                  clk_fall;    // one cycle on filtered falling edge
    logic [10:0]           frame;       // start, 8 data, parity, stop
    logic [3:0]            bit_cnt;
    logic                  frame_done;
    logic                  frame_good;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clk_sync  <= 2'b11;                 // lines idle high
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    // the filtered level only flips once the history is unanimous
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clk_hist <= '1;
            clk_filt <= 1'b1;
            clk_fall <= 1'b0;
        end else begin
            clk_hist <= {clk_hist[FILTER_LEN-2:0], clk_sync[1]};
            clk_fall <= 1'b0;
            if (clk_filt && clk_hist == '0) begin
                clk_filt <= 1'b0;
                clk_fall <= 1'b1;
            end else if (!clk_filt && clk_hist == '1) begin
                clk_filt <= 1'b1;
            end
        end
    end

    // bits arrive lsb first, so the start bit ends up in frame[0]
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt    <= 4'd0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (clk_fall) begin
                if (bit_cnt == 4'd10) begin
                    bit_cnt    <= 4'd0;
                    frame_done <= 1'b1;     // eleventh bit in
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clk_fall)
            frame <= {data_sync[1], frame[10:1]};
    end

    // odd parity over data and parity bit together
    assign frame_good = !frame[0] && frame[10] && (^frame[9:1]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            rx_valid <= 1'b0;
        else
            rx_valid <= frame_done && frame_good;   // bad frames dropped silently
    end

    always_ff @(posedge clk) begin
        if (frame_done)
            rx_byte <= frame[8:1];
    end

endmodule

/* verilog/key_decoder.sv */
`timescale 1ns/100ps

module key_decoder import ps2_kbd_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic [7:0]   rx_byte,
    input  logic         rx_valid,
    output logic [511:0] key_down,
    output key_code_u    last_change,
    output logic         key_valid
);

    logic      ext_pend;    // E0 seen for the current key
    logic      brk_pend;    // F0 seen for the current key
    logic      is_prefix;
    logic      key_done;    // plain byte ends the sequence
    key_code_u code;

    assign is_prefix = (rx_byte == SCAN_EXT) || (rx_byte == SCAN_BREAK);
    assign key_done  = rx_valid && !is_prefix;

    always_comb begin
        code.fields.ext  = ext_pend;
        code.fields.scan = rx_byte;
    end

    // prefix flags collect until the scan byte arrives
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ext_pend <= 1'b0;
            brk_pend <= 1'b0;
        end else if (rx_valid) begin
            if (rx_byte == SCAN_EXT) begin
                ext_pend <= 1'b1;
            end else if (rx_byte == SCAN_BREAK) begin
                brk_pend <= 1'b1;
            end else begin
                ext_pend <= 1'b0;
                brk_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_down  <= '0;
            key_valid <= 1'b0;
        end else begin
            key_valid <= key_done;
            if (key_done)
                key_down[code.raw] <= !brk_pend;  // make sets, break clears
        end
    end

    // code of the last completed make or break
    always_ff @(posedge clk) begin
        if (key_done)
            last_change <= code;
    end

endmodule

/* verilog/digit_entry.sv */
`timescale 1ns/100ps

module digit_entry import ps2_kbd_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic [511:0] key_down,
    input  key_code_u    last_change,
    input  logic         key_valid,
    output logic [15:0]  nums
);

    logic [3:0] key_num;        // digit for last_change, or blank
    logic       shift_down;
    logic       is_press;

    assign shift_down = key_down[LEFT_SHIFT_CODE] || key_down[RIGHT_SHIFT_CODE];

    // key map already reflects this event, so the bit tells make from break
    assign is_press = key_down[last_change.raw];

    // main row and keypad share digit values
    always_comb begin
        key_num = BLANK_NIBBLE;
        for (int i = 0; i < 20; i++) begin
            if (last_change.raw == DIGIT_CODES[i])
                key_num = 4'(i % 10);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            nums <= {4{BLANK_NIBBLE}};      // all four positions blank
        end else if (key_valid && is_press && key_num != BLANK_NIBBLE) begin
            if (shift_down)
                nums <= {nums[11:0], key_num};  // enter at position 0
            else
                nums <= {key_num, nums[15:4]};  // enter at position 3
        end
    end

endmodule

/* verilog/seven_seg_scan.sv */
`timescale 1ns/100ps

module seven_seg_scan import ps2_kbd_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] nums,
    output logic [3:0]  digit,
    output logic [6:0]  display
);

    logic [SCAN_DIV_BITS+1:0] scan_cnt;     // top two bits select position
    logic [1:0]               pos;
    logic [3:0]               nibble;
    logic [3:0]               seg_idx;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            scan_cnt <= '0;
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    assign pos    = scan_cnt[SCAN_DIV_BITS+1:SCAN_DIV_BITS];
    assign nibble = nums[{pos, 2'b00} +: 4];

    // anything above 9 shows as blank
    assign seg_idx = (nibble > 4'd9) ? 4'd10 : nibble;

    // anode and segments move together
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            digit   <= 4'b1110;             // position 0
            display <= SEG_PATTERNS[10];
        end else begin
            digit   <= ~(4'b0001 << pos);   // one-cold anode
            display <= SEG_PATTERNS[seg_idx];
        end
    end

endmodule

/* verilog/kbd_digit_top.sv */
`timescale 1ns/100ps

module kbd_digit_top import ps2_kbd_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic [3:0] digit,
    output logic [6:0] display
);

    logic [7:0]   rx_byte;
    logic         rx_valid;
    logic [511:0] key_down;
    key_code_u    last_change;
    logic         key_valid;
    logic [15:0]  nums;

    ps2_rx ps2_rx_i (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    key_decoder key_decoder_i (
        .clk         (clk),
        .rst         (rst),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .key_down    (key_down),
        .last_change (last_change),
        .key_valid   (key_valid)
    );

    digit_entry digit_entry_i (
        .clk         (clk),
        .rst         (rst),
        .key_down    (key_down),
        .last_change (last_change),
        .key_valid   (key_valid),
        .nums        (nums)
    );

    seven_seg_scan seven_seg_scan_i (
        .clk     (clk),
        .rst     (rst),
        .nums    (nums),
        .digit   (digit),
        .display (display)
    );

endmodule

/* verification/tb_kbd_digit.sv */
`timescale 1ns/100ps

module tb_kbd_digit import ps2_kbd_pkg::*; ();

    localparam int CLK_HALF      = 5;
    localparam int RESET_CYCLES  = 10;
    localparam int PS2_HALF      = 20;      // system cycles per ps2 clock half
    localparam int FRAME_GAP     = 20;
    localparam int SETTLE_CYCLES = 16;
    localparam int SCAN_PERIOD   = 64;      // four positions of 16 cycles

    localparam int NUM_PLAIN   = 12;
    localparam int NUM_SHIFTED = 6;
    localparam int NUM_OTHER   = 10;
    localparam int NUM_BAD     = 4;

    // upper bounds, extended keys counted at full length
    localparam int NUM_FRAMES = NUM_PLAIN * 3 + 2 * (1 + NUM_SHIFTED * 3 + 2 + 3)
                              + NUM_OTHER * 5 + NUM_BAD * 4;
    localparam int NUM_CHECKS = 1 + NUM_PLAIN * 2 + 2 * (1 + NUM_SHIFTED * 2 + 1 + 2)
                              + NUM_OTHER * 2 + NUM_BAD * 3;
    localparam int CHECK_CYCLES   = SETTLE_CYCLES + 2 * SCAN_PERIOD + 1;
    localparam int TIMEOUT_CYCLES = 2 * (NUM_FRAMES * 11 * 2 * PS2_HALF
                                  + NUM_CHECKS * CHECK_CYCLES + RESET_CYCLES);

    localparam logic [8:0] LSHIFT_KEY = 9'h012;
    localparam logic [8:0] RSHIFT_KEY = 9'h059;

    // main row 0..9, then keypad 0..9
    localparam logic [8:0] DIGIT_KEYS [20] = '{
        9'h045, 9'h016, 9'h01E, 9'h026, 9'h025,
        9'h02E, 9'h036, 9'h03D, 9'h03E, 9'h046,
        9'h070, 9'h069, 9'h072, 9'h07A, 9'h06B,
        9'h073, 9'h074, 9'h06C, 9'h075, 9'h07D
    };

    // segments gfedcba, low means lit; last entry is blank
    localparam logic [6:0] SEG_REF [11] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
        7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0010000,
        7'b1111111
    };

    logic         clk = 1'b0;
    logic         rst;
    logic         ps2_clk;
    logic         ps2_data;
    logic [3:0]   digit;
    logic [6:0]   display;

    logic [15:0]  nums_model;
    logic [511:0] held_keys;       // keys the model thinks are down
    int           cycle_cnt = 0;

    kbd_digit_top kbd_digit_top_i (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .digit    (digit),
        .display  (display)
    );

    always #CLK_HALF clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Test failed");
            $fatal(1, "timeout: the run did not finish within %0d clock cycles", cycle_cnt);
        end
    end

    // returns 1 ns after a rising edge, where inputs change
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic send_frame(input logic [7:0] data, input logic good_parity);
        logic [10:0] bits;
        logic        par;
        par = ~^data;                       // odd parity over data plus parity
        if (!good_parity)
            par = ~par;
        bits = {1'b1, par, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_data = bits[i];             // data changes while clock is high
            wait_cycles(PS2_HALF);
            ps2_clk = 1'b0;
            wait_cycles(PS2_HALF);
            ps2_clk = 1'b1;
        end
        wait_cycles(FRAME_GAP);
    endtask

    function automatic key_code_u make_code(input logic [8:0] raw);
        key_code_u k;
        k.raw = raw;
        return k;
    endfunction

    function automatic int key_digit(input logic [8:0] code);
        int value;
        value = -1;                         // not a digit key
        for (int i = 0; i < 20; i++)
            if (code == DIGIT_KEYS[i])
                value = i % 10;
        return value;
    endfunction

    function automatic key_code_u random_digit_key(input int row);
        return make_code(DIGIT_KEYS[$urandom_range(0, 9) + row * 10]);
    endfunction

    function automatic key_code_u random_other_key();
        key_code_u k;
        do begin
            k.fields.ext  = 1'($urandom_range(0, 1));
            k.fields.scan = 8'($urandom_range(1, 127));   // never a prefix byte
        end while (key_digit(k.raw) >= 0 || k.raw == LSHIFT_KEY || k.raw == RSHIFT_KEY);
        return k;
    endfunction

    task automatic press_key(input key_code_u code);
        int d;
        if (code.fields.ext)
            send_frame(8'hE0, 1'b1);
        send_frame(code.fields.scan, 1'b1);
        held_keys[code.raw] = 1'b1;
        d = key_digit(code.raw);
        if (d >= 0) begin
            if (held_keys[LSHIFT_KEY] || held_keys[RSHIFT_KEY])
                nums_model = {nums_model[11:0], 4'(d)};     // in at position 0
            else
                nums_model = {4'(d), nums_model[15:4]};     // in at position 3
        end
    endtask

    task automatic release_key(input key_code_u code);
        if (code.fields.ext)
            send_frame(8'hE0, 1'b1);
        send_frame(8'hF0, 1'b1);
        send_frame(code.fields.scan, 1'b1);
        held_keys[code.raw] = 1'b0;
    endtask

    function automatic logic [3:0] decode_segments(input logic [6:0] seg);
        logic [3:0] value;
        value = 4'hE;                       // no known pattern
        for (int i = 0; i < 11; i++)
            if (seg == SEG_REF[i])
                value = (i == 10) ? 4'hF : 4'(i);
        return value;
    endfunction

    task automatic check_anode(input logic [3:0] observed);
        int low_bits;
        low_bits = 0;
        for (int i = 0; i < 4; i++)
            if (!observed[i])
                low_bits++;
        if (low_bits != 1) begin
            $display("ERR %0t digit: expected 1 low bit, got %0d low bits (%b)",
                     $time, low_bits, observed);
            $display("Test failed");
            $fatal(1, "anode compare failed");
        end
    endtask

    task automatic check_digit(input logic [1:0] position, input logic [3:0] expected,
                               input logic [6:0] observed);
        logic [3:0] shown;
        shown = decode_segments(observed);
        if (shown !== expected) begin
            $display("ERR %0t display position %0d: expected %h, got %h (segments %b)",
                     $time, position, expected, shown, observed);
            $display("Test failed");
            $fatal(1, "display compare failed");
        end
    endtask

    // one full scan after settling, every position must show up
    task automatic check_display();
        logic [3:0] seen;
        int         pos;
        seen = '0;
        wait_cycles(SETTLE_CYCLES + SCAN_PERIOD);
        for (int c = 0; c < SCAN_PERIOD; c++) begin
            @(negedge clk);
            check_anode(digit);
            pos = 0;
            for (int i = 0; i < 4; i++)
                if (!digit[i])
                    pos = i;
            check_digit(2'(pos), nums_model[pos*4 +: 4], display);
            seen[pos] = 1'b1;
        end
        if (seen != 4'b1111) begin
            $display("Test failed");
            $fatal(1, "not all four anodes were driven during one scan, seen %b", seen);
        end
        wait_cycles(1);
    endtask

    initial begin
        key_code_u key;
        key_code_u shift_key;
        void'($urandom(32'hb2e7));
        rst        = 1'b1;
        ps2_clk    = 1'b1;                  // idle bus
        ps2_data   = 1'b1;
        nums_model = 16'hFFFF;
        held_keys  = '0;
        wait_cycles(RESET_CYCLES);
        rst = 1'b0;

        check_display();                    // all blank after reset

        for (int i = 0; i < NUM_PLAIN; i++) begin
            key = random_digit_key(i % 2);  // alternate main row and keypad
            press_key(key);
            check_display();
            release_key(key);
            check_display();
        end

        for (int s = 0; s < 2; s++) begin
            shift_key = make_code((s == 0) ? LSHIFT_KEY : RSHIFT_KEY);
            press_key(shift_key);
            check_display();
            for (int i = 0; i < NUM_SHIFTED; i++) begin
                key = random_digit_key($urandom_range(0, 1));
                press_key(key);
                check_display();
                release_key(key);
                check_display();
            end
            release_key(shift_key);
            check_display();
            key = random_digit_key(s);      // back to entry at position 3
            press_key(key);
            check_display();
            release_key(key);
            check_display();
        end

        for (int i = 0; i < NUM_OTHER; i++) begin
            key = random_other_key();
            press_key(key);
            check_display();
            release_key(key);
            check_display();
        end

        // corrupted make code first, then the same key sent cleanly
        for (int i = 0; i < NUM_BAD; i++) begin
            key = random_digit_key(i % 2);
            send_frame(key.fields.scan, 1'b0);
            check_display();
            press_key(key);
            check_display();
            release_key(key);
            check_display();
        end

        $display("Test passed");
        $finish;
    end

endmodule

/* tb.f */
verilog/ps2_kbd_pkg.sv
verilog/ps2_rx.sv
verilog/key_decoder.sv
verilog/digit_entry.sv
verilog/seven_seg_scan.sv
verilog/kbd_digit_top.sv
verification/tb_kbd_digit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the keyboard digit testbench with Verilator.
set -e

cd "$(dirname "$0")"

log_file=sim.log

rm -rf obj_dir
verilator --binary --timing -f tb.f --top-module tb_kbd_digit -o sim_kbd_digit

# the simulator exits non-zero on a fatal check, so the log decides
./obj_dir/sim_kbd_digit > "$log_file" 2>&1 || true
cat "$log_file"

if grep -q "Test failed" "$log_file"; then
    echo "simulation reported a failure, see $log_file"
    exit 1
fi

echo "simulation finished without a reported failure"
exit 0
